//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, AND, OR, XOR, NOR, LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        NONE, BEQ, BNE, ALWAYS
    } branch_kind_t;

    ////////////////////////////////////////////////////////////////////////////
    // instruction formats, all views of the same 32-bit word
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [16:0] opcode;
        reg_addr_t   rk;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } r3_fmt_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } ri12_fmt_t;

    // b and bl keep offset bits 25:16 in the rj and rd slots
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } ri16_fmt_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] imm20;
        reg_addr_t   rd;
    } ri20_fmt_t;

    typedef union packed {
        r3_fmt_t   r3;
        ri12_fmt_t ri12;
        ri16_fmt_t ri16;
        ri20_fmt_t ri20;
    } inst_word_u;

    // 3R format, bits 31:15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_SLTU  = 17'h00025;
    localparam logic [16:0] OP_NOR   = 17'h00028;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;
    // 2RI12 format, bits 31:22
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;
    // offset formats, bits 31:26
    localparam logic [5:0]  OP_B   = 6'h14;
    localparam logic [5:0]  OP_BL  = 6'h15;
    localparam logic [5:0]  OP_BEQ = 6'h16;
    localparam logic [5:0]  OP_BNE = 6'h17;
    // 1RI20 format, bits 31:25
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;

    ////////////////////////////////////////////////////////////////////////////
    // stage registers and side channels
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic         valid;
        word_t        pc;
        alu_op_t      alu_op;
        logic         src1_is_pc;
        logic         src2_is_imm;
        word_t        imm;
        word_t        rdata1;
        word_t        rdata2;
        reg_addr_t    rj;
        reg_addr_t    rk_or_rd;
        reg_addr_t    dest;
        logic         gr_we;
        logic         mem_we;
        logic         res_from_mem;
        branch_kind_t branch_kind;
        word_t        br_target;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        word_t     store_data;
        reg_addr_t dest;
        logic      gr_we;
        logic      mem_we;
        logic      res_from_mem;
    } ex_mem_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } data_req_t;

    typedef struct packed {
        word_t     pc;
        logic      we;
        reg_addr_t wnum;
        word_t     wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import cpu_pkg::*; #(
    parameter word_t RESET_PC = 32'h1c000000
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall,
    input  redirect_t redirect,
    output word_t     inst_addr,
    input  word_t     inst,
    output if_id_t    if_id
);

    word_t pc;
    word_t next_pc;

    // redirect wins over the load stall
    always_comb begin
        if (redirect.taken) begin
            next_pc = redirect.target;
        end else if (stall) begin
            next_pc = pc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if_id.pc    <= pc;
        if_id.inst  <= inst;
        if_id.valid <= !(stall || redirect.taken);
        if (reset) begin
            if_id.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  if_id_t    if_id,
    input  redirect_t redirect,
    input  rf_write_t rf_write,
    output logic      stall,
    output id_ex_t    id_ex
);

    inst_word_u iw;
    logic       is_add_w, is_sub_w, is_slt, is_sltu;
    logic       is_and, is_or, is_xor, is_nor;
    logic       is_addi_w, is_ld_w, is_st_w, is_lu12i_w;
    logic       is_b, is_bl, is_beq, is_bne;
    logic       src_reg_is_rd;
    logic       writes_reg;
    reg_addr_t  raddr2;
    reg_addr_t  dest;
    word_t      rdata1;
    word_t      rdata2;
    word_t      imm;
    word_t      br_offs;
    logic [25:0] offs26;
    alu_op_t    alu_op;
    branch_kind_t branch_kind;

    assign iw = if_id.inst;

    ////////////////////////////////////////////////////////////////////////////
    // opcode match
    ////////////////////////////////////////////////////////////////////////////
    assign is_add_w   = iw.r3.opcode == OP_ADD_W;
    assign is_sub_w   = iw.r3.opcode == OP_SUB_W;
    assign is_slt     = iw.r3.opcode == OP_SLT;
    assign is_sltu    = iw.r3.opcode == OP_SLTU;
    assign is_and     = iw.r3.opcode == OP_AND;
    assign is_or      = iw.r3.opcode == OP_OR;
    assign is_xor     = iw.r3.opcode == OP_XOR;
    assign is_nor     = iw.r3.opcode == OP_NOR;
    assign is_addi_w  = iw.ri12.opcode == OP_ADDI_W;
    assign is_ld_w    = iw.ri12.opcode == OP_LD_W;
    assign is_st_w    = iw.ri12.opcode == OP_ST_W;
    assign is_b       = iw.ri16.opcode == OP_B;
    assign is_bl      = iw.ri16.opcode == OP_BL;
    assign is_beq     = iw.ri16.opcode == OP_BEQ;
    assign is_bne     = iw.ri16.opcode == OP_BNE;
    assign is_lu12i_w = iw.ri20.opcode == OP_LU12I_W;

    // stores and conditional branches compare or store rd
    assign src_reg_is_rd = is_st_w || is_beq || is_bne;
    assign raddr2 = src_reg_is_rd ? iw.r3.rd : iw.r3.rk;

    // bl links into r1
    assign dest = is_bl ? 5'd1 : iw.r3.rd;
    assign writes_reg = is_add_w || is_sub_w || is_slt || is_sltu || is_and || is_or
                     || is_xor || is_nor || is_addi_w || is_lu12i_w || is_ld_w || is_bl;

    register_file u_register_file (
        .clk    (clk),
        .we     (rf_write.we),
        .waddr  (rf_write.addr),
        .wdata  (rf_write.data),
        .raddr1 (iw.r3.rj),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // immediate; bl adds 4 to the pc for its link value
    always_comb begin
        if (is_bl) begin
            imm = 32'd4;
        end else if (is_lu12i_w) begin
            imm = {iw.ri20.imm20, 12'b0};
        end else begin
            imm = {{20{iw.ri12.imm12[11]}}, iw.ri12.imm12};
        end
    end

    always_comb begin
        if (is_sub_w)        alu_op = SUB;
        else if (is_slt)     alu_op = SLT;
        else if (is_sltu)    alu_op = SLTU;
        else if (is_and)     alu_op = AND;
        else if (is_or)      alu_op = OR;
        else if (is_xor)     alu_op = XOR;
        else if (is_nor)     alu_op = NOR;
        else if (is_lu12i_w) alu_op = LUI;
        else                 alu_op = ADD;
    end

    always_comb begin
        if (is_beq)              branch_kind = BEQ;
        else if (is_bne)         branch_kind = BNE;
        else if (is_b || is_bl)  branch_kind = ALWAYS;
        else                     branch_kind = NONE;
    end

    // 26-bit offset of b and bl
    assign offs26 = {iw.ri16.rj, iw.ri16.rd, iw.ri16.offs16};
    assign br_offs = (is_b || is_bl) ? {{4{offs26[25]}}, offs26, 2'b00}
                                     : {{14{iw.ri16.offs16[15]}}, iw.ri16.offs16, 2'b00};

    // one bubble behind every load
    assign stall = if_id.valid && is_ld_w;

    always_ff @(posedge clk) begin
        id_ex.valid        <= if_id.valid && !redirect.taken;
        id_ex.pc           <= if_id.pc;
        id_ex.alu_op       <= alu_op;
        id_ex.src1_is_pc   <= is_bl;
        id_ex.src2_is_imm  <= is_addi_w || is_ld_w || is_st_w || is_lu12i_w || is_bl;
        id_ex.imm          <= imm;
        id_ex.rdata1       <= rdata1;
        id_ex.rdata2       <= rdata2;
        id_ex.rj           <= iw.r3.rj;
        id_ex.rk_or_rd     <= raddr2;
        id_ex.dest         <= dest;
        id_ex.gr_we        <= writes_reg && dest != 5'd0;
        id_ex.mem_we       <= is_st_w;
        id_ex.res_from_mem <= is_ld_w;
        id_ex.branch_kind  <= branch_kind;
        id_ex.br_target    <= if_id.pc + br_offs;
        if (reset) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  id_ex_t    id_ex,
    input  rf_write_t rf_write,
    output redirect_t redirect,
    output ex_mem_t   ex_mem
);

    rf_write_t rf_write_q;
    word_t     fwd1;
    word_t     fwd2;
    word_t     src1;
    word_t     src2;
    word_t     alu_result;
    logic      operands_eq;

    // value written one cycle ago, missed by the decode read
    always_ff @(posedge clk) begin
        rf_write_q <= rf_write;
        if (reset) begin
            rf_write_q.we <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // forwarding, youngest producer first
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t forward(input reg_addr_t addr, input word_t rf_value);
        if (addr == 5'd0) begin
            return rf_value;
        end
        if (ex_mem.valid && ex_mem.gr_we && ex_mem.dest == addr) begin
            return ex_mem.result;
        end
        if (rf_write.we && rf_write.addr == addr) begin
            return rf_write.data;
        end
        if (rf_write_q.we && rf_write_q.addr == addr) begin
            return rf_write_q.data;
        end
        return rf_value;
    endfunction

    always_comb begin
        fwd1 = forward(id_ex.rj, id_ex.rdata1);
        fwd2 = forward(id_ex.rk_or_rd, id_ex.rdata2);
    end

    assign src1 = id_ex.src1_is_pc ? id_ex.pc : fwd1;
    assign src2 = id_ex.src2_is_imm ? id_ex.imm : fwd2;

    always_comb begin
        case (id_ex.alu_op)
            SUB:     alu_result = src1 - src2;
            SLT:     alu_result = {31'b0, $signed(src1) < $signed(src2)};
            SLTU:    alu_result = {31'b0, src1 < src2};
            AND:     alu_result = src1 & src2;
            OR:      alu_result = src1 | src2;
            XOR:     alu_result = src1 ^ src2;
            NOR:     alu_result = ~(src1 | src2);
            // imm already holds the shifted upper bits
            LUI:     alu_result = src2;
            default: alu_result = src1 + src2;
        endcase
    end

    // branch resolution on forwarded rj and rd
    assign operands_eq = fwd1 == fwd2;
    assign redirect.taken = id_ex.valid
                         && (id_ex.branch_kind == ALWAYS
                         || (id_ex.branch_kind == BEQ && operands_eq)
                         || (id_ex.branch_kind == BNE && !operands_eq));
    assign redirect.target = id_ex.br_target;

    always_ff @(posedge clk) begin
        ex_mem.valid        <= id_ex.valid;
        ex_mem.pc           <= id_ex.pc;
        ex_mem.result       <= alu_result;
        ex_mem.store_data   <= fwd2;
        ex_mem.dest         <= id_ex.dest;
        ex_mem.gr_we        <= id_ex.gr_we;
        ex_mem.mem_we       <= id_ex.mem_we;
        ex_mem.res_from_mem <= id_ex.res_from_mem;
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  ex_mem_t   ex_mem,
    input  word_t     data_rdata,
    output data_req_t data_req,
    output rf_write_t rf_write,
    output wb_trace_t wb_trace
);

    wb_trace_t mem_wb;

    // address comes from the ALU, data is the forwarded rd
    assign data_req.we    = ex_mem.valid && ex_mem.mem_we;
    assign data_req.addr  = ex_mem.result;
    assign data_req.wdata = ex_mem.store_data;

    always_ff @(posedge clk) begin
        mem_wb.pc    <= ex_mem.pc;
        mem_wb.we    <= ex_mem.valid && ex_mem.gr_we;
        mem_wb.wnum  <= ex_mem.dest;
        mem_wb.wdata <= ex_mem.res_from_mem ? data_rdata : ex_mem.result;
        if (reset) begin
            mem_wb.we <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // writeback
    ////////////////////////////////////////////////////////////////////////////
    assign rf_write.we   = mem_wb.we;
    assign rf_write.addr = mem_wb.wnum;
    assign rf_write.data = mem_wb.wdata;

    assign wb_trace = mem_wb;

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter word_t RESET_PC = 32'h1c000000
) (
    input  logic      clk,
    input  logic      reset,
    output word_t     inst_addr,
    input  word_t     inst,
    output data_req_t data_req,
    input  word_t     data_rdata,
    output wb_trace_t wb_trace
);

    logic      stall;
    redirect_t redirect;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    rf_write_t rf_write;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .inst_addr (inst_addr),
        .inst      (inst),
        .if_id     (if_id)
    );

    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .if_id    (if_id),
        .redirect (redirect),
        .rf_write (rf_write),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex),
        .rf_write (rf_write),
        .redirect (redirect),
        .ex_mem   (ex_mem)
    );

    memory_stage u_memory (
        .clk        (clk),
        .reset      (reset),
        .ex_mem     (ex_mem),
        .data_rdata (data_rdata),
        .data_req   (data_req),
        .rf_write   (rf_write),
        .wb_trace   (wb_trace)
    );

endmodule

`default_nettype wire

//--- verification/cpu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_properties import cpu_pkg::*; (
    input logic      clk,
    input logic      reset,
    input word_t     inst_addr,
    input data_req_t data_req,
    input wb_trace_t wb_trace
);

    a_inst_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_addr[1:0] == 2'b00)
        else $error("instruction address not word aligned");

    a_no_r0_write: assert property (@(posedge clk) disable iff (reset)
        wb_trace.we |-> wb_trace.wnum != 5'd0)
        else $error("trace write targets r0");

    // first cycle out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !data_req.we && !wb_trace.we)
        else $error("write enable high right after reset");

endmodule

bind cpu_top cpu_properties u_properties (
    .clk       (clk),
    .reset     (reset),
    .inst_addr (inst_addr),
    .data_req  (data_req),
    .wb_trace  (wb_trace)
);

`default_nettype wire

//--- verification/cpu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_checker import cpu_pkg::*; #(
    parameter word_t RESET_PC = 32'h1c000000
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [2:0] test_no,
    input  word_t      prog [64],
    input  data_req_t  data_req,
    input  wb_trace_t  wb_trace,
    output logic       done,
    output int         errors
);

    word_t     regs [32];
    word_t     mem [256];
    wb_trace_t exp_trace [$];
    data_req_t exp_store [$];
    logic      active;
    int        err_total;
    int        test_errors;
    int        n_checked;

    assign errors = err_total;

    initial begin
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 3)};
        end
        done      = 1'b0;
        active    = 1'b0;
        err_total = 0;
    end

    task automatic write_reg(input reg_addr_t n, input word_t v, input word_t pc);
        if (n != 5'd0) begin
            regs[n] = v;
            exp_trace.push_back('{pc, 1'b1, n, v});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model, one instruction at a time
    ////////////////////////////////////////////////////////////////////////////
    task automatic run_model();
        int i;
        int offs;
        word_t w;
        word_t pc;
        word_t a;
        word_t b;
        word_t sx12;
        word_t addr;
        logic [25:0] offs26;
        reg_addr_t rd;
        exp_trace.delete();
        exp_store.delete();
        i = 0;
        for (int steps = 0; steps < 256; steps++) begin
            w      = prog[i];
            pc     = RESET_PC + 32'(i) * 32'd4;
            rd     = w[4:0];
            a      = regs[w[9:5]];
            b      = regs[w[14:10]];
            sx12   = {{20{w[21]}}, w[21:10]};
            addr   = a + sx12;
            offs26 = {w[9:0], w[25:10]};
            offs   = 1;
            if (w[31:26] == OP_B && offs26 == 26'd0) begin
                break;
            end
            if (w[31:26] == OP_B || w[31:26] == OP_BL) begin
                offs = int'($signed(offs26));
                if (w[31:26] == OP_BL) begin
                    write_reg(5'd1, pc + 32'd4, pc);
                end
            end else if (w[31:26] == OP_BEQ || w[31:26] == OP_BNE) begin
                if ((a == regs[rd]) == (w[31:26] == OP_BEQ)) begin
                    offs = int'($signed(w[25:10]));
                end
            end else if (w[31:22] == OP_ADDI_W) begin
                write_reg(rd, addr, pc);
            end else if (w[31:22] == OP_LD_W) begin
                write_reg(rd, mem[addr[9:2]], pc);
            end else if (w[31:22] == OP_ST_W) begin
                mem[addr[9:2]] = regs[rd];
                exp_store.push_back('{1'b1, addr, regs[rd]});
            end else if (w[31:25] == OP_LU12I_W) begin
                write_reg(rd, {w[24:5], 12'd0}, pc);
            end else begin
                case (w[31:15])
                    OP_ADD_W: write_reg(rd, a + b, pc);
                    OP_SUB_W: write_reg(rd, a - b, pc);
                    OP_SLT:   write_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, pc);
                    OP_SLTU:  write_reg(rd, (a < b) ? 32'd1 : 32'd0, pc);
                    OP_AND:   write_reg(rd, a & b, pc);
                    OP_OR:    write_reg(rd, a | b, pc);
                    OP_XOR:   write_reg(rd, a ^ b, pc);
                    default:  write_reg(rd, ~(a | b), pc);
                endcase
            end
            i = i + offs;
        end
    endtask

    task automatic report_error();
        test_errors++;
        err_total++;
    endtask

    // compare in program order
    always @(posedge clk) begin
        if (start) begin
            run_model();
            active      <= 1'b1;
            done        <= 1'b0;
            test_errors = 0;
            n_checked   = 0;
        end else if (active && !reset) begin
            if (wb_trace.we) begin
                n_checked++;
                if (exp_trace.size() == 0) begin
                    report_error();
                    $display("unexpected register write to r%0d at pc %h",
                             wb_trace.wnum, wb_trace.pc);
                end else if (exp_trace[0] != wb_trace) begin
                    report_error();
                    $display("FAILED %0t: pc %h wrote r%0d=%h, expected pc %h r%0d=%h",
                             $time, wb_trace.pc, wb_trace.wnum, wb_trace.wdata,
                             exp_trace[0].pc, exp_trace[0].wnum, exp_trace[0].wdata);
                    void'(exp_trace.pop_front());
                end else begin
                    void'(exp_trace.pop_front());
                end
            end
            if (data_req.we) begin
                n_checked++;
                if (exp_store.size() == 0) begin
                    report_error();
                    $display("unexpected store to address %h", data_req.addr);
                end else begin
                    if (exp_store[0] != data_req) begin
                        report_error();
                        $display("FAILED %0t: store %h to %h, expected %h to %h", $time,
                                 data_req.wdata, data_req.addr,
                                 exp_store[0].wdata, exp_store[0].addr);
                    end
                    void'(exp_store.pop_front());
                end
            end
            if (exp_trace.size() == 0 && exp_store.size() == 0) begin
                $display("test %0d: %0d writes checked, %0d errors",
                         test_no, n_checked, test_errors);
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam word_t RESET_PC = 32'h1c000000;
    localparam int NUM_TESTS = 5;
    localparam int CYCLE_LIMIT = NUM_TESTS * (64 * 3 + 60);

    logic      clk;
    logic      reset;
    logic      start;
    logic [2:0] test_no;
    logic      done;
    int        errors;
    int        cycles;
    word_t     inst_addr;
    word_t     inst;
    word_t     data_rdata;
    data_req_t data_req;
    wb_trace_t wb_trace;
    word_t     prog [64];
    word_t     dmem [256];
    reg_addr_t recent [3];

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .inst_addr  (inst_addr),
        .inst       (inst),
        .data_req   (data_req),
        .data_rdata (data_rdata),
        .wb_trace   (wb_trace)
    );

    cpu_checker #(
        .RESET_PC (RESET_PC)
    ) u_checker (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .test_no  (test_no),
        .prog     (prog),
        .data_req (data_req),
        .wb_trace (wb_trace),
        .done     (done),
        .errors   (errors)
    );

    ////////////////////////////////////////////////////////////////////////////
    // combinational-read memories
    ////////////////////////////////////////////////////////////////////////////
    assign inst       = prog[inst_addr[7:2]];
    assign data_rdata = dmem[data_req.addr[9:2]];

    always @(posedge clk) begin
        if (data_req.we) begin
            dmem[data_req.addr[9:2]] <= data_req.wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // pipeline must keep retiring
    always @(posedge clk) begin
        if (!reset) begin
            cycles <= cycles + 1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: pipeline stopped retiring");
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // program generator
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t ri12_inst(input logic [9:0] op, input logic [11:0] imm,
                                        input reg_addr_t rj, input reg_addr_t rd);
        return {op, imm, rj, rd};
    endfunction

    // a register that none of the last three instructions wrote
    function automatic reg_addr_t distant_reg();
        reg_addr_t r;
        r = 5'($urandom);
        while (r == recent[0] || r == recent[1] || r == recent[2]) begin
            r = 5'($urandom);
        end
        return r;
    endfunction

    function automatic word_t alu_inst(input reg_addr_t rd, input reg_addr_t rj,
                                       input reg_addr_t rk);
        case ($urandom % 10)
            0: return {OP_ADD_W, rk, rj, rd};
            1: return {OP_SUB_W, rk, rj, rd};
            2: return {OP_SLT, rk, rj, rd};
            3: return {OP_SLTU, rk, rj, rd};
            4: return {OP_AND, rk, rj, rd};
            5: return {OP_OR, rk, rj, rd};
            6: return {OP_XOR, rk, rj, rd};
            7: return {OP_NOR, rk, rj, rd};
            8: return ri12_inst(OP_ADDI_W, 12'($urandom), rj, rd);
            default: return {OP_LU12I_W, 20'($urandom), rd};
        endcase
    endfunction

    // forward only and never past the last slot
    function automatic word_t branch_inst(input int idx, input reg_addr_t rj,
                                          input reg_addr_t rd);
        int k;
        reg_addr_t rd_cmp;
        k = 1 + $urandom % 4;
        if (idx + k > 63) begin
            k = 63 - idx;
        end
        rd_cmp = ($urandom % 2 == 0) ? rj : rd;
        case ($urandom % 4)
            0: return {OP_B, 16'(k), 10'd0};
            1: return {OP_BL, 16'(k), 10'd0};
            2: return {OP_BEQ, 16'(k), rj, rd_cmp};
            default: return {OP_BNE, 16'(k), rj, rd_cmp};
        endcase
    endfunction

    task automatic build_program(input int t);
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t near;
        int pick;
        for (int i = 0; i < 64; i++) begin
            // r0 as a destination now and then
            rd   = 5'($urandom);
            rj   = 5'($urandom);
            rk   = 5'($urandom);
            near = recent[$urandom % 3];
            pick = $urandom % 8;
            if (i == 63) begin
                // branch-to-self ends the program
                prog[i] = {OP_B, 26'd0};
            end else if (t == 1 && i < 31) begin
                rd      = 5'(i + 1);
                prog[i] = ri12_inst(OP_ADDI_W, 12'($urandom), 5'd0, rd);
            end else begin
                case (t)
                    1: prog[i] = alu_inst(rd, distant_reg(), distant_reg());
                    2: prog[i] = alu_inst(rd, recent[0], near);
                    3: begin
                        if (pick < 3) begin
                            prog[i] = ri12_inst(OP_LD_W, 12'($urandom), rj, rd);
                        end else if (pick < 6) begin
                            prog[i] = ri12_inst(OP_ST_W, 12'($urandom), rj, rd);
                        end else begin
                            prog[i] = alu_inst(rd, recent[0], rk);
                        end
                    end
                    4: prog[i] = (pick < 4) ? branch_inst(i, rj, rd)
                                            : alu_inst(rd, near, rk);
                    default: begin
                        if (pick < 2) begin
                            prog[i] = branch_inst(i, near, rd);
                        end else if (pick == 2) begin
                            prog[i] = ri12_inst(OP_LD_W, 12'($urandom), rj, rd);
                        end else if (pick == 3) begin
                            prog[i] = ri12_inst(OP_ST_W, 12'($urandom), rj, near);
                        end else begin
                            prog[i] = alu_inst(rd, near, rk);
                        end
                    end
                endcase
            end
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = rd;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(33));
        reset   = 1'b1;
        start   = 1'b0;
        test_no = 3'd0;
        cycles  = 0;
        recent  = '{5'd1, 5'd2, 5'd3};
        for (int i = 0; i < 64; i++) begin
            prog[i] = {OP_B, 26'd0};
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a, 8'(i * 3)};
        end
        for (int t = 1; t <= NUM_TESTS; t++) begin
            @(posedge clk);
            reset <= 1'b1;
            @(posedge clk);
            build_program(t);
            start   <= 1'b1;
            test_no <= 3'(t);
            @(posedge clk);
            start <= 1'b0;
            repeat (14) @(posedge clk);
            reset <= 1'b0;
            while (!done) begin
                @(posedge clk);
            end
        end
        $display("tests run: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hw/cpu_pkg.sv
hw/register_file.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
verification/cpu_properties.sv
verification/cpu_checker.sv
verification/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cpu_tb \
    --Mdir obj_dir -o cpu_sim \
    && ./obj_dir/cpu_sim | tee sim.log \
    && ! grep -q "FAIL: see errors above" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
